//--- verilog/cpu_isa_pkg.sv
package cpu_isa_pkg;

	// bus and register width
	localparam int WORD_WIDTH = 32;

	// instruction word layout
	localparam int OPC_MSB = 31;
	localparam int OPC_LSB = 27;
	localparam int REG_FIELD_WIDTH = 4;
	localparam int RA_LSB = 26;
	localparam int RB_LSB = 22;
	localparam int RC_LSB = 18;
	// constant field sits in the low bits
	localparam int IMM_WIDTH = 19;

	// any code not listed decodes as halt
	typedef enum logic [4:0] {
		op_ld   = 5'd0,
		op_st   = 5'd1,
		op_ldi  = 5'd2,
		op_addi = 5'd3,
		op_andi = 5'd4,
		op_ori  = 5'd5,
		op_add  = 5'd6,
		op_sub  = 5'd7,
		op_and  = 5'd8,
		op_or   = 5'd9,
		op_halt = 5'd10
	} opcode_t;

	// alu functions
	typedef enum logic [1:0] {
		alu_add = 2'd0,
		alu_sub = 2'd1,
		alu_and = 2'd2,
		alu_or  = 2'd3
	} alu_op_t;

endpackage

//--- verilog/cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

	// sequencer steps
	typedef enum logic [3:0] {
		st_idle        = 4'd0,
		// instruction fetch
		st_fetch_addr  = 4'd1,
		st_fetch_mem   = 4'd2,
		st_decode      = 4'd3,
		// operand and alu steps
		st_load_y      = 4'd4,
		st_exec        = 4'd5,
		st_writeback   = 4'd6,
		// memory instructions
		st_mem_addr    = 4'd7,
		st_store_data  = 4'd8,
		st_mem_access  = 4'd9,
		st_load_result = 4'd10,
		// parked until reset
		st_halted      = 4'd11
	} step_t;

endpackage

//--- verilog/register_file.sv
`timescale 1ns/1ns

module register_file (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic [cpu_isa_pkg::WORD_WIDTH-1:0] ir,
	input  logic                               gra,
	input  logic                               grb,
	input  logic                               grc,
	input  logic                               r_in,
	input  logic                               ba_out,
	input  logic [cpu_isa_pkg::WORD_WIDTH-1:0] bus_in,
	output logic [cpu_isa_pkg::WORD_WIDTH-1:0] reg_data
);

	localparam int SEL_W = cpu_isa_pkg::REG_FIELD_WIDTH;
	localparam int NUM_REGS = 1 << SEL_W;

	logic [cpu_isa_pkg::WORD_WIDTH-1:0] regs [NUM_REGS];
	logic [SEL_W-1:0] sel;

	// register number from the ir field picked by the select strobes
	always_comb begin
		if (gra)
			sel = ir[cpu_isa_pkg::RA_LSB +: SEL_W];
		else if (grb)
			sel = ir[cpu_isa_pkg::RB_LSB +: SEL_W];
		else if (grc)
			sel = ir[cpu_isa_pkg::RC_LSB +: SEL_W];
		else
			sel = '0;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (r_in) begin
			regs[sel] <= bus_in;
		end
	end

	// base addressing reads r0 as zero
	assign reg_data = (ba_out && sel == '0) ? '0 : regs[sel];

endmodule

//--- verilog/alu.sv
`timescale 1ns/1ns

module alu (
	input  logic [cpu_isa_pkg::WORD_WIDTH-1:0] y,
	input  logic [cpu_isa_pkg::WORD_WIDTH-1:0] b,
	input  cpu_isa_pkg::alu_op_t               alu_op,
	input  logic                               pc_increment,
	output logic [cpu_isa_pkg::WORD_WIDTH-1:0] result
);

	logic [cpu_isa_pkg::WORD_WIDTH-1:0] op_result;

	// y is the first operand, the bus is the second
	always_comb begin
		case (alu_op)
			cpu_isa_pkg::alu_add:
				op_result = y + b;
			cpu_isa_pkg::alu_sub:
				op_result = y - b;
			cpu_isa_pkg::alu_and:
				op_result = y & b;
			cpu_isa_pkg::alu_or:
				op_result = y | b;
			default:
				op_result = y + b;
		endcase
	end

	// pc increment overrides the selected function
	assign result = pc_increment ? b + 1'b1 : op_result;

endmodule

//--- verilog/datapath.sv
`timescale 1ns/1ns

module datapath #(
	parameter int ADDR_WIDTH = 12
) (
	input  logic                               clk,
	input  logic                               rst_n,
	// bus sources
	input  logic                               pc_out,
	input  logic                               zlo_out,
	input  logic                               mdr_out,
	input  logic                               r_out,
	input  logic                               ba_out,
	input  logic                               c_sext_out,
	// register loads
	input  logic                               pc_enable,
	input  logic                               mar_enable,
	input  logic                               mdr_enable,
	input  logic                               ir_enable,
	input  logic                               y_enable,
	input  logic                               z_enable,
	input  logic                               r_in,
	input  logic                               gra,
	input  logic                               grb,
	input  logic                               grc,
	input  logic                               pc_increment,
	input  cpu_isa_pkg::alu_op_t               alu_op,
	input  logic                               mdr_from_mem,
	input  logic [cpu_isa_pkg::WORD_WIDTH-1:0] mem_rdata,
	output cpu_isa_pkg::opcode_t               opcode,
	output logic [ADDR_WIDTH-1:0]              mem_addr,
	output logic [cpu_isa_pkg::WORD_WIDTH-1:0] mem_wdata
);

	localparam int WW = cpu_isa_pkg::WORD_WIDTH;

	logic [WW-1:0] bus;
	logic [WW-1:0] pc;
	logic [WW-1:0] mdr;
	logic [WW-1:0] ir;
	logic [WW-1:0] y;
	logic [WW-1:0] z;
	logic [WW-1:0] reg_data;
	logic [WW-1:0] alu_result;
	logic [WW-1:0] c_sext;
	logic [ADDR_WIDTH-1:0] mar;
	logic [cpu_isa_pkg::OPC_MSB-cpu_isa_pkg::OPC_LSB:0] opc_field;

	register_file register_file_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.ir       (ir),
		.gra      (gra),
		.grb      (grb),
		.grc      (grc),
		.r_in     (r_in),
		.ba_out   (ba_out),
		.bus_in   (bus),
		.reg_data (reg_data)
	);

	alu alu_inst (
		.y            (y),
		.b            (bus),
		.alu_op       (alu_op),
		.pc_increment (pc_increment),
		.result       (alu_result)
	);

	// sign extended constant field of ir
	assign c_sext = {{(WW - cpu_isa_pkg::IMM_WIDTH){ir[cpu_isa_pkg::IMM_WIDTH-1]}},
		ir[cpu_isa_pkg::IMM_WIDTH-1:0]};

	// and-or bus carries zero when nothing drives it
	assign bus = ({WW{pc_out}} & pc)
		| ({WW{zlo_out}} & z)
		| ({WW{mdr_out}} & mdr)
		| ({WW{r_out | ba_out}} & reg_data)
		| ({WW{c_sext_out}} & c_sext);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc  <= '0;
			mar <= '0;
			ir  <= '0;
			y   <= '0;
			z   <= '0;
		end else begin
			if (pc_enable)
				pc <= bus;
			if (mar_enable)
				mar <= bus[ADDR_WIDTH-1:0];
			if (ir_enable)
				ir <= bus;
			if (y_enable)
				y <= bus;
			if (z_enable)
				z <= alu_result;
		end
	end

	always_ff @(posedge clk) begin
		if (mdr_enable)
			mdr <= mdr_from_mem ? mem_rdata : bus;
	end

	// while ir loads, decode sees the fetched word in mdr
	assign opc_field = ir_enable ? mdr[cpu_isa_pkg::OPC_MSB:cpu_isa_pkg::OPC_LSB]
		: ir[cpu_isa_pkg::OPC_MSB:cpu_isa_pkg::OPC_LSB];
	assign opcode = cpu_isa_pkg::opcode_t'(opc_field);

	assign mem_addr = mar;
	assign mem_wdata = mdr;

endmodule

//--- verilog/control_unit.sv
`timescale 1ns/1ns

module control_unit (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 run,
	input  cpu_isa_pkg::opcode_t opcode,
	input  logic                 mem_ack,
	output logic                 pc_out,
	output logic                 zlo_out,
	output logic                 mdr_out,
	output logic                 r_out,
	output logic                 ba_out,
	output logic                 c_sext_out,
	output logic                 pc_enable,
	output logic                 mar_enable,
	output logic                 mdr_enable,
	output logic                 ir_enable,
	output logic                 y_enable,
	output logic                 z_enable,
	output logic                 r_in,
	output logic                 gra,
	output logic                 grb,
	output logic                 grc,
	output logic                 pc_increment,
	output cpu_isa_pkg::alu_op_t alu_op,
	output logic                 mdr_from_mem,
	output logic                 mem_req,
	output logic                 mem_we,
	output logic                 halted
);

	cpu_ctrl_pkg::step_t state;
	cpu_ctrl_pkg::step_t next_state;
	cpu_isa_pkg::alu_op_t exec_op;
	logic base_form;
	logic imm_form;
	logic is_mem;
	logic in_access;
	logic req_done;
	logic access_done;

	// instruction class from the opcode
	always_comb begin
		base_form = 1'b0;
		imm_form = 1'b0;
		is_mem = 1'b0;
		exec_op = cpu_isa_pkg::alu_add;
		case (opcode)
			cpu_isa_pkg::op_ld, cpu_isa_pkg::op_st: begin
				base_form = 1'b1;
				imm_form = 1'b1;
				is_mem = 1'b1;
			end
			cpu_isa_pkg::op_ldi: begin
				base_form = 1'b1;
				imm_form = 1'b1;
			end
			cpu_isa_pkg::op_addi:
				imm_form = 1'b1;
			cpu_isa_pkg::op_andi: begin
				imm_form = 1'b1;
				exec_op = cpu_isa_pkg::alu_and;
			end
			cpu_isa_pkg::op_ori: begin
				imm_form = 1'b1;
				exec_op = cpu_isa_pkg::alu_or;
			end
			cpu_isa_pkg::op_sub:
				exec_op = cpu_isa_pkg::alu_sub;
			cpu_isa_pkg::op_and:
				exec_op = cpu_isa_pkg::alu_and;
			cpu_isa_pkg::op_or:
				exec_op = cpu_isa_pkg::alu_or;
			default: ;
		endcase
	end

	// req stays high until ack and the step then waits for ack low
	assign in_access = (state == cpu_ctrl_pkg::st_fetch_mem)
		|| (state == cpu_ctrl_pkg::st_mem_access);
	assign mem_req = in_access && !req_done;
	assign access_done = in_access && req_done && !mem_ack;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			req_done <= 1'b0;
		else if (mem_req && mem_ack)
			req_done <= 1'b1;
		else if (access_done)
			req_done <= 1'b0;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= cpu_ctrl_pkg::st_idle;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		case (state)
			cpu_ctrl_pkg::st_idle:
				if (run)
					next_state = cpu_ctrl_pkg::st_fetch_addr;
			cpu_ctrl_pkg::st_fetch_addr:
				next_state = cpu_ctrl_pkg::st_fetch_mem;
			cpu_ctrl_pkg::st_fetch_mem:
				if (access_done)
					next_state = cpu_ctrl_pkg::st_decode;
			cpu_ctrl_pkg::st_decode:
				if (opcode <= cpu_isa_pkg::op_or)
					next_state = cpu_ctrl_pkg::st_load_y;
				else
					next_state = cpu_ctrl_pkg::st_halted;
			cpu_ctrl_pkg::st_load_y:
				next_state = cpu_ctrl_pkg::st_exec;
			cpu_ctrl_pkg::st_exec:
				next_state = is_mem ? cpu_ctrl_pkg::st_mem_addr : cpu_ctrl_pkg::st_writeback;
			cpu_ctrl_pkg::st_mem_addr:
				next_state = (opcode == cpu_isa_pkg::op_st) ? cpu_ctrl_pkg::st_store_data
					: cpu_ctrl_pkg::st_mem_access;
			cpu_ctrl_pkg::st_store_data:
				next_state = cpu_ctrl_pkg::st_mem_access;
			cpu_ctrl_pkg::st_mem_access:
				if (access_done)
					next_state = (opcode == cpu_isa_pkg::op_ld) ? cpu_ctrl_pkg::st_load_result
						: cpu_ctrl_pkg::st_fetch_addr;
			cpu_ctrl_pkg::st_writeback, cpu_ctrl_pkg::st_load_result:
				next_state = cpu_ctrl_pkg::st_fetch_addr;
			cpu_ctrl_pkg::st_halted:
				next_state = cpu_ctrl_pkg::st_halted;
			default:
				next_state = cpu_ctrl_pkg::st_idle;
		endcase
	end

	// decode loads ir while the datapath forwards the opcode from mdr
	assign ir_enable = (state == cpu_ctrl_pkg::st_decode);

	always_comb begin
		pc_out = 1'b0;
		zlo_out = 1'b0;
		mdr_out = 1'b0;
		r_out = 1'b0;
		ba_out = 1'b0;
		c_sext_out = 1'b0;
		pc_enable = 1'b0;
		mar_enable = 1'b0;
		mdr_enable = 1'b0;
		y_enable = 1'b0;
		z_enable = 1'b0;
		r_in = 1'b0;
		gra = 1'b0;
		grb = 1'b0;
		grc = 1'b0;
		pc_increment = 1'b0;
		alu_op = cpu_isa_pkg::alu_add;
		mdr_from_mem = 1'b0;
		mem_we = 1'b0;
		case (state)
			cpu_ctrl_pkg::st_fetch_addr: begin
				pc_out = 1'b1;
				mar_enable = 1'b1;
				pc_increment = 1'b1;
				z_enable = 1'b1;
			end
			cpu_ctrl_pkg::st_fetch_mem: begin
				zlo_out = 1'b1;
				pc_enable = 1'b1;
				mdr_from_mem = 1'b1;
				mdr_enable = mem_req && mem_ack;
			end
			cpu_ctrl_pkg::st_decode:
				mdr_out = 1'b1;
			cpu_ctrl_pkg::st_load_y: begin
				grb = 1'b1;
				y_enable = 1'b1;
				ba_out = base_form;
				r_out = !base_form;
			end
			cpu_ctrl_pkg::st_exec: begin
				z_enable = 1'b1;
				alu_op = exec_op;
				c_sext_out = imm_form;
				grc = !imm_form;
				r_out = !imm_form;
			end
			cpu_ctrl_pkg::st_writeback: begin
				zlo_out = 1'b1;
				gra = 1'b1;
				r_in = 1'b1;
			end
			cpu_ctrl_pkg::st_mem_addr: begin
				zlo_out = 1'b1;
				mar_enable = 1'b1;
			end
			cpu_ctrl_pkg::st_store_data: begin
				gra = 1'b1;
				r_out = 1'b1;
				mdr_enable = 1'b1;
			end
			cpu_ctrl_pkg::st_mem_access: begin
				mdr_from_mem = 1'b1;
				mem_we = (opcode == cpu_isa_pkg::op_st);
				mdr_enable = (opcode != cpu_isa_pkg::op_st) && mem_req && mem_ack;
			end
			cpu_ctrl_pkg::st_load_result: begin
				mdr_out = 1'b1;
				gra = 1'b1;
				r_in = 1'b1;
			end
			default: ;
		endcase
	end

	assign halted = (state == cpu_ctrl_pkg::st_halted);

endmodule

//--- verilog/mini_cpu.sv
`timescale 1ns/1ns

module mini_cpu #(
	parameter int ADDR_WIDTH = 12
) (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               run,
	output logic                               halted,
	output logic                               mem_req,
	output logic                               mem_we,
	output logic [ADDR_WIDTH-1:0]              mem_addr,
	output logic [cpu_isa_pkg::WORD_WIDTH-1:0] mem_wdata,
	input  logic                               mem_ack,
	input  logic [cpu_isa_pkg::WORD_WIDTH-1:0] mem_rdata
);

	// strobes from the sequencer
	logic pc_out;
	logic zlo_out;
	logic mdr_out;
	logic r_out;
	logic ba_out;
	logic c_sext_out;
	logic pc_enable;
	logic mar_enable;
	logic mdr_enable;
	logic ir_enable;
	logic y_enable;
	logic z_enable;
	logic r_in;
	logic gra;
	logic grb;
	logic grc;
	logic pc_increment;
	logic mdr_from_mem;
	cpu_isa_pkg::alu_op_t alu_op;
	// opcode back to the sequencer
	cpu_isa_pkg::opcode_t opcode;

	control_unit control_unit_inst (.*);

	datapath #(
		.ADDR_WIDTH (ADDR_WIDTH)
	) datapath_inst (.*);

endmodule

//--- verif/mini_cpu_tb.sv
`timescale 1ns/1ns

module mini_cpu_tb;

	localparam int ADDR_WIDTH = 12;
	localparam int MEM_WORDS = 1 << ADDR_WIDTH;
	localparam int WW = cpu_isa_pkg::WORD_WIDTH;
	localparam int RW = cpu_isa_pkg::REG_FIELD_WIDTH;
	localparam int IW = cpu_isa_pkg::IMM_WIDTH;
	// worst case for one instruction with two slow handshakes
	localparam int CYCLES_PER_INSTR = 26;
	localparam int HALT_WATCH = 50;
	localparam int ACC_NONE = 0;
	localparam int ACC_READ = 1;
	localparam int ACC_WRITE = 2;
	localparam int ACC_HALT = 3;

	typedef logic [15:0][WW-1:0] reg_model_t;

	logic clk;
	logic rst_n;
	logic run;
	logic halted;
	logic mem_req;
	logic mem_we;
	logic [ADDR_WIDTH-1:0] mem_addr;
	logic [WW-1:0] mem_wdata;
	logic mem_ack;
	logic [WW-1:0] mem_rdata;

	logic [WW-1:0] mem [MEM_WORDS];
	logic [WW-1:0] ref_mem [MEM_WORDS];
	logic [ADDR_WIDTH-1:0] exp_addr_q [$];
	logic exp_we_q [$];
	logic [WW-1:0] exp_data_q [$];
	logic [31:0] rng_state = 32'd81;
	logic req_prev = 1'b0;
	int errors = 0;
	int prog_len = 0;
	int n_exp_writes = 0;
	int n_writes = 0;
	int n_trans = 0;
	int cycle_limit = 2000;

	mini_cpu #(
		.ADDR_WIDTH (ADDR_WIDTH)
	) mini_cpu_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.run       (run),
		.halted    (halted),
		.mem_req   (mem_req),
		.mem_we    (mem_we),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_ack   (mem_ack),
		.mem_rdata (mem_rdata)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int draw_delay(input int max_cycles);
		rng_state = xorshift32(rng_state);
		return int'(rng_state % 32'(max_cycles + 1));
	endfunction

	function automatic logic [WW-1:0] encode_instr(input logic [4:0] op, input logic [RW-1:0] ra,
		input logic [RW-1:0] rb, input logic [RW-1:0] rc, input logic [IW-1:0] imm);
		logic [WW-1:0] word;
		word = WW'(imm);
		word = word | (WW'(rc) << cpu_isa_pkg::RC_LSB);
		word = word | (WW'(rb) << cpu_isa_pkg::RB_LSB);
		word = word | (WW'(ra) << cpu_isa_pkg::RA_LSB);
		word = word | (WW'(op) << cpu_isa_pkg::OPC_LSB);
		return word;
	endfunction

	// expected effect of one instruction on the register model
	function automatic reg_model_t exec_ref(input logic [WW-1:0] instr, input reg_model_t regs_in,
		output int access, output logic [ADDR_WIDTH-1:0] addr, output logic [WW-1:0] data);
		reg_model_t regs;
		logic [4:0] op;
		logic [RW-1:0] ra;
		logic [RW-1:0] rb;
		logic [RW-1:0] rc;
		logic [WW-1:0] c;
		logic [WW-1:0] ea;
		regs = regs_in;
		op = instr[cpu_isa_pkg::OPC_MSB:cpu_isa_pkg::OPC_LSB];
		ra = instr[cpu_isa_pkg::RA_LSB +: RW];
		rb = instr[cpu_isa_pkg::RB_LSB +: RW];
		rc = instr[cpu_isa_pkg::RC_LSB +: RW];
		c = WW'(instr[IW-1:0]);
		if (instr[IW-1])
			c = c | ~((WW'(1) << IW) - WW'(1));
		// base form sees r0 as zero
		ea = ((rb == '0) ? '0 : regs[rb]) + c;
		access = ACC_NONE;
		addr = '0;
		data = '0;
		case (op)
			cpu_isa_pkg::op_ldi:  regs[ra] = ea;
			cpu_isa_pkg::op_addi: regs[ra] = regs[rb] + c;
			cpu_isa_pkg::op_andi: regs[ra] = regs[rb] & c;
			cpu_isa_pkg::op_ori:  regs[ra] = regs[rb] | c;
			cpu_isa_pkg::op_add:  regs[ra] = regs[rb] + regs[rc];
			cpu_isa_pkg::op_sub:  regs[ra] = regs[rb] - regs[rc];
			cpu_isa_pkg::op_and:  regs[ra] = regs[rb] & regs[rc];
			cpu_isa_pkg::op_or:   regs[ra] = regs[rb] | regs[rc];
			cpu_isa_pkg::op_ld: begin
				access = ACC_READ;
				addr = ea[ADDR_WIDTH-1:0];
				data = ref_mem[addr];
				regs[ra] = data;
			end
			cpu_isa_pkg::op_st: begin
				access = ACC_WRITE;
				addr = ea[ADDR_WIDTH-1:0];
				data = regs[ra];
			end
			default: access = ACC_HALT;
		endcase
		return regs;
	endfunction

	task automatic put_instr(input logic [4:0] op, input logic [RW-1:0] ra,
		input logic [RW-1:0] rb, input logic [RW-1:0] rc, input logic [IW-1:0] imm);
		logic [WW-1:0] word;
		word = encode_instr(op, ra, rb, rc, imm);
		// ra shares its upper bits with the opcode
		if (word[cpu_isa_pkg::RA_LSB +: RW] != ra) begin
			errors++;
			$display("test program cannot encode destination r%0d at %0d", ra, prog_len);
		end
		mem[prog_len] = word;
		prog_len++;
	endtask

	task automatic expect_access(input logic [ADDR_WIDTH-1:0] addr, input logic we,
		input logic [WW-1:0] data);
		exp_addr_q.push_back(addr);
		exp_we_q.push_back(we);
		exp_data_q.push_back(data);
	endtask

	task automatic check_access(input logic [ADDR_WIDTH-1:0] e_addr, input logic e_we,
		input logic [WW-1:0] e_data);
		if (mem_addr !== e_addr) begin
			errors++;
			$display("ERROR: mem_addr = 0x%h, expected 0x%h (access %0d)",
				mem_addr, e_addr, n_trans);
		end
		if (mem_we !== e_we) begin
			errors++;
			$display("ERROR: mem_we = 0x%h, expected 0x%h (access %0d)",
				mem_we, e_we, n_trans);
		end
		if (e_we && mem_wdata !== e_data) begin
			errors++;
			$display("ERROR: mem_wdata = 0x%h, expected 0x%h (access %0d)",
				mem_wdata, e_data, n_trans);
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// memory with random ack delays
	initial begin
		int delay;
		mem_ack = 1'b0;
		mem_rdata = '0;
		forever begin
			@(negedge clk);
			if (rst_n && mem_req && !mem_ack) begin
				delay = draw_delay(3);
				repeat (delay) @(negedge clk);
				@(posedge clk);
				#2;
				mem_ack = 1'b1;
				mem_rdata = mem[mem_addr];
				if (mem_we)
					mem[mem_addr] = mem_wdata;
				do @(negedge clk); while (mem_req);
				delay = draw_delay(2);
				repeat (delay) @(negedge clk);
				@(posedge clk);
				#2;
				mem_ack = 1'b0;
			end
		end
	end

	// compare each access as the DUT starts it
	always @(negedge clk) begin
		if (rst_n && mem_req && !req_prev) begin
			n_trans++;
			if (mem_we)
				n_writes++;
			if (mem_ack) begin
				errors++;
				$display("mem_req rose while mem_ack was still high (access %0d)", n_trans);
			end
			if (exp_addr_q.size() == 0) begin
				errors++;
				$display("memory access at 0x%h that the program does not make", mem_addr);
			end else begin
				check_access(exp_addr_q.pop_front(), exp_we_q.pop_front(), exp_data_q.pop_front());
			end
		end
		req_prev = mem_req;
	end

	initial begin
		int cycle_count;
		cycle_count = 0;
		while (cycle_count < cycle_limit) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout after %0d cycles without the CPU halting", cycle_limit);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		int acc;
		int pc;
		logic walking;
		logic [ADDR_WIDTH-1:0] acc_addr;
		logic [WW-1:0] acc_data;
		reg_model_t model;
		rst_n = 1'b0;
		run = 1'b0;
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = {8'hC3, 12'(i), 12'(~i)};
		mem[12'h800] = 32'h8765_4321;
		mem[12'h801] = 32'h0BAD_F00D;
		put_instr(cpu_isa_pkg::op_ldi, 4'd4, 4'd0, 4'd0, 19'h00123);
		put_instr(cpu_isa_pkg::op_ldi, 4'd5, 4'd0, 4'd0, 19'h7FFFB);
		put_instr(cpu_isa_pkg::op_ldi, 4'd4, 4'd4, 4'd0, 19'h03F00);
		put_instr(cpu_isa_pkg::op_addi, 4'd6, 4'd5, 4'd0, 19'h00007);
		put_instr(cpu_isa_pkg::op_addi, 4'd7, 4'd4, 4'd0, 19'h7FFFF);
		put_instr(cpu_isa_pkg::op_andi, 4'd8, 4'd5, 4'd0, 19'h0F0F0);
		put_instr(cpu_isa_pkg::op_andi, 4'd9, 4'd7, 4'd0, 19'h7FF00);
		put_instr(cpu_isa_pkg::op_ori, 4'd10, 4'd6, 4'd0, 19'h40000);
		put_instr(cpu_isa_pkg::op_ori, 4'd11, 4'd4, 4'd0, 19'h00500);
		put_instr(cpu_isa_pkg::op_add, 4'd12, 4'd5, 4'd10, 19'h0);
		put_instr(cpu_isa_pkg::op_add, 4'd13, 4'd11, 4'd9, 19'h0);
		put_instr(cpu_isa_pkg::op_sub, 4'd14, 4'd6, 4'd4, 19'h0);
		put_instr(cpu_isa_pkg::op_sub, 4'd15, 4'd8, 4'd9, 19'h0);
		put_instr(cpu_isa_pkg::op_or, 4'd3, 4'd12, 4'd13, 19'h0);
		put_instr(cpu_isa_pkg::op_ld, 4'd1, 4'd0, 4'd0, 19'h00800);
		put_instr(cpu_isa_pkg::op_ld, 4'd0, 4'd6, 4'd0, 19'h007FF);
		// r0 now holds data but base reads must still see zero
		put_instr(cpu_isa_pkg::op_ldi, 4'd5, 4'd0, 4'd0, 19'h00001);
		put_instr(cpu_isa_pkg::op_add, 4'd12, 4'd0, 4'd1, 19'h0);
		put_instr(cpu_isa_pkg::op_and, 4'd1, 4'd10, 4'd11, 19'h0);
		put_instr(cpu_isa_pkg::op_st, 4'd2, 4'd0, 4'd0, 19'h00902);
		put_instr(cpu_isa_pkg::op_st, 4'd3, 4'd0, 4'd0, 19'h00903);
		// st only reaches r2 and r3, so copy each register through r2
		for (int k = 0; k < 16; k++) begin
			if (k != 2 && k != 3) begin
				put_instr(cpu_isa_pkg::op_or, 4'd2, 4'(k), 4'(k), 19'h0);
				put_instr(cpu_isa_pkg::op_st, 4'd2, 4'd0, 4'd0, 19'h00900 + 19'(k));
			end
		end
		put_instr(cpu_isa_pkg::op_halt, 4'd4, 4'd0, 4'd0, 19'h0);
		for (int i = 0; i < MEM_WORDS; i++)
			ref_mem[i] = mem[i];
		// expected access sequence
		model = '0;
		walking = 1'b1;
		pc = 0;
		while (walking && pc < MEM_WORDS) begin
			expect_access(ADDR_WIDTH'(pc), 1'b0, '0);
			model = exec_ref(ref_mem[pc], model, acc, acc_addr, acc_data);
			if (acc == ACC_HALT) begin
				walking = 1'b0;
			end else if (acc != ACC_NONE) begin
				expect_access(acc_addr, acc == ACC_WRITE, acc_data);
				if (acc == ACC_WRITE) begin
					ref_mem[acc_addr] = acc_data;
					n_exp_writes++;
				end
			end
			pc++;
		end
		cycle_limit = 30 + pc * CYCLES_PER_INSTR + HALT_WATCH;
		repeat (2) @(posedge clk);
		#2;
		rst_n = 1'b1;
		repeat (10) begin
			@(negedge clk);
			if (mem_req || halted) begin
				errors++;
				$display("mem_req or halted went high while run was low");
			end
		end
		@(posedge clk);
		#2;
		run = 1'b1;
		while (!halted)
			@(negedge clk);
		repeat (HALT_WATCH) begin
			@(negedge clk);
			if (mem_req) begin
				errors++;
				$display("memory request after the CPU halted");
			end
			if (!halted) begin
				errors++;
				$display("halted dropped before reset");
			end
		end
		if (exp_addr_q.size() != 0) begin
			errors++;
			$display("%0d expected memory accesses never happened", exp_addr_q.size());
		end
		if (n_writes != n_exp_writes) begin
			errors++;
			$display("ERROR: write count = 0x%h, expected 0x%h", n_writes, n_exp_writes);
		end
		$display("errors: %0d, accesses: %0d, writes: %0d of %0d",
			errors, n_trans, n_writes, n_exp_writes);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

//--- mini_cpu.f
verilog/cpu_isa_pkg.sv
verilog/cpu_ctrl_pkg.sv
verilog/register_file.sv
verilog/alu.sv
verilog/datapath.sv
verilog/control_unit.sv
verilog/mini_cpu.sv
verif/mini_cpu_tb.sv

//--- Makefile
SIM := obj_dir/Vmini_cpu_tb

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

$(SIM): mini_cpu.f $(shell cat mini_cpu.f)
	verilator --binary --timing -Wno-fatal --top-module mini_cpu_tb -f mini_cpu.f

clean:
	rm -rf obj_dir
